// File: build.f
+incdir+.
hssl_pkg.sv
config_regs.sv
event_mapper.sv
route_table.sv
drop_timer.sv
router_ctrl.sv
dvs_hssl_router_top.sv
tb_checker.sv
tb_dvs_hssl_router.sv

// File: config_regs.sv
// --------------------------------------------------
// configuration registers written through cfg_* port
// plus the routed and dropped packet counters
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module config_regs
  import hssl_pkg::*;
(
  input  logic         pl_clk0_buf_int,
  input  logic         rst_n,

  // configuration write port
  input  cfg_addr_t    cfg_addr,
  input  key_t         cfg_wdata,
  input  logic         cfg_en,

  // one-cycle pulses from router_ctrl
  input  logic         cnt_routed,
  input  logic         cnt_dropped,

  // event mapper settings
  output key_t         mp_key,
  output fmsk_array_t  mp_fmsk,
  output fsft_array_t  mp_fsft,

  // routing table
  output key_array_t   rt_key,
  output key_array_t   rt_mask,
  output route_array_t rt_route,

  output key_t         drop_wait,

  // statistics
  output key_t         routed_count,
  output key_t         dropped_count
);

  // --------------------------------------------------
  // write decode
  // --------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
    begin
      mp_key    <= '0;
      mp_fmsk   <= '0;
      mp_fsft   <= '0;
      rt_key    <= '0;
      rt_mask   <= '0;
      rt_route  <= '0;
      drop_wait <= '0;
    end
    else if (cfg_en)
    begin
      // single-word registers
      if (cfg_addr == `HSSL_ADDR_MP_KEY)
        mp_key <= cfg_wdata;
      if (cfg_addr == `HSSL_ADDR_DROP_WAIT)
        drop_wait <= cfg_wdata;

      // mapper fields
      for (int i = 0; i < `HSSL_NUM_MREGS; i++)
      begin
        if (cfg_addr == cfg_addr_t'(`HSSL_ADDR_MP_FMSK + i))
          mp_fmsk[i] <= cfg_wdata;
        if (cfg_addr == cfg_addr_t'(`HSSL_ADDR_MP_FSFT + i))
          mp_fsft[i] <= cfg_wdata[`HSSL_SHIFT_BITS-1:0];
      end

      // routing entries, unmapped addresses fall through
      for (int i = 0; i < `HSSL_NUM_RREGS; i++)
      begin
        if (cfg_addr == cfg_addr_t'(`HSSL_ADDR_RT_KEY + i))
          rt_key[i] <= cfg_wdata;
        if (cfg_addr == cfg_addr_t'(`HSSL_ADDR_RT_MASK + i))
          rt_mask[i] <= cfg_wdata;
        if (cfg_addr == cfg_addr_t'(`HSSL_ADDR_RT_ROUTE + i))
          rt_route[i] <= cfg_wdata[`HSSL_ROUTE_BITS-1:0];
      end
    end
  end

  // --------------------------------------------------
  // statistics counters
  // --------------------------------------------------
  // both wrap silently at full scale
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
    begin
      routed_count  <= '0;
      dropped_count <= '0;
    end
    else
    begin
      if (cnt_routed)
        routed_count <= routed_count + key_t'(1);
      if (cnt_dropped)
        dropped_count <= dropped_count + key_t'(1);
    end
  end

endmodule

// File: drop_timer.sv
// --------------------------------------------------
// drop wait timer, loaded on each offered packet
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module drop_timer
  import hssl_pkg::*;
(
  input  logic pl_clk0_buf_int,
  input  logic rst_n,
  input  key_t drop_wait,
  input  logic timer_start,
  input  logic timer_stop,
  output logic timer_expired
);

  key_t count;
  logic running;

  // flags the last waiting cycle, count is about to hit zero
  assign timer_expired = running && (count == key_t'(1));

  // running flag, a zero load never runs
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
      running <= 1'b0;
    else if (timer_stop)
      running <= 1'b0;
    else if (timer_start)
      running <= (drop_wait != '0);
    else if (timer_expired)
      running <= 1'b0;
  end

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (timer_start)
      count <= drop_wait;
    else if (running)
      count <= count - key_t'(1);
  end

  // a stop silences the timer from the next cycle
  stop_quiet: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
      timer_stop |=> !timer_expired)
    else $error("drop_timer: expired after stop");

endmodule

// File: dvs_hssl_router_top.sv
// --------------------------------------------------
// router top: config registers, mapper, route table,
// drop timer and channel control
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module dvs_hssl_router_top
  import hssl_pkg::*;
(
  input  logic                          pl_clk0_buf_int,
  input  logic                          rst_n,
  // configuration writes
  input  cfg_addr_t                     cfg_addr,
  input  key_t                          cfg_wdata,
  input  logic                          cfg_en,
  // events
  input  key_t                          evt_data,
  input  logic                          evt_vld,
  output logic                          evt_rdy,
  // channels
  output key_t                          out_key,
  output logic [`HSSL_NUM_CHANNELS-1:0] out_vld,
  input  logic [`HSSL_NUM_CHANNELS-1:0] out_rdy,
  // statistics
  output key_t                          routed_count,
  output key_t                          dropped_count
);

  // --------------------------------------------------
  // internal signals
  // --------------------------------------------------
  key_t         mp_key;
  fmsk_array_t  mp_fmsk;
  fsft_array_t  mp_fsft;
  key_array_t   rt_key;
  key_array_t   rt_mask;
  route_array_t rt_route;
  key_t         drop_wait;

  // mapper to table
  key_t         map_key;
  logic         map_vld;
  logic         map_rdy;

  // table to controller
  key_t         rtd_key;
  route_t       rtd_route;
  logic         rtd_hit;
  logic         rtd_vld;
  logic         rtd_rdy;

  logic         timer_start;
  logic         timer_stop;
  logic         timer_expired;
  logic         cnt_routed;
  logic         cnt_dropped;

  config_regs cr (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .cfg_addr        (cfg_addr)
    , .cfg_wdata       (cfg_wdata)
    , .cfg_en          (cfg_en)
    , .cnt_routed      (cnt_routed)
    , .cnt_dropped     (cnt_dropped)
    , .mp_key          (mp_key)
    , .mp_fmsk         (mp_fmsk)
    , .mp_fsft         (mp_fsft)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
    , .drop_wait       (drop_wait)
    , .routed_count    (routed_count)
    , .dropped_count   (dropped_count)
    );

  // stage 1
  event_mapper em (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .mp_key          (mp_key)
    , .mp_fmsk         (mp_fmsk)
    , .mp_fsft         (mp_fsft)
    , .map_key         (map_key)
    , .map_vld         (map_vld)
    , .map_rdy         (map_rdy)
    );

  // stage 2
  route_table rt (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .map_key         (map_key)
    , .map_vld         (map_vld)
    , .map_rdy         (map_rdy)
    , .rt_key          (rt_key)
    , .rt_mask         (rt_mask)
    , .rt_route        (rt_route)
    , .rtd_key         (rtd_key)
    , .rtd_route       (rtd_route)
    , .rtd_hit         (rtd_hit)
    , .rtd_vld         (rtd_vld)
    , .rtd_rdy         (rtd_rdy)
    );

  drop_timer dt (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .drop_wait       (drop_wait)
    , .timer_start     (timer_start)
    , .timer_stop      (timer_stop)
    , .timer_expired   (timer_expired)
    );

  // stage 3, channel offer
  router_ctrl rc (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .rtd_key         (rtd_key)
    , .rtd_route       (rtd_route)
    , .rtd_hit         (rtd_hit)
    , .rtd_vld         (rtd_vld)
    , .rtd_rdy         (rtd_rdy)
    , .out_key         (out_key)
    , .out_vld         (out_vld)
    , .out_rdy         (out_rdy)
    , .timer_start     (timer_start)
    , .timer_stop      (timer_stop)
    , .timer_expired   (timer_expired)
    , .cnt_routed      (cnt_routed)
    , .cnt_dropped     (cnt_dropped)
    );

endmodule

// File: event_mapper.sv
// --------------------------------------------------
// maps an event word to a multicast key
// one registered valid/ready stage
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module event_mapper
  import hssl_pkg::*;
(
  input  logic        pl_clk0_buf_int,
  input  logic        rst_n,

  // incoming event
  input  key_t        evt_data,
  input  logic        evt_vld,
  output logic        evt_rdy,

  // mapper settings
  input  key_t        mp_key,
  input  fmsk_array_t mp_fmsk,
  input  fsft_array_t mp_fsft,

  // mapped key to route_table
  output key_t        map_key,
  output logic        map_vld,
  input  logic        map_rdy
);

  key_t map_key_nxt;

  // base key ORed with each masked and shifted field
  always_comb
  begin
    map_key_nxt = mp_key;
    for (int i = 0; i < `HSSL_NUM_MREGS; i++)
      map_key_nxt = map_key_nxt | ((evt_data & mp_fmsk[i]) >> mp_fsft[i]);
  end

  // accept when empty or when the held key leaves
  assign evt_rdy = !map_vld || map_rdy;

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
      map_vld <= 1'b0;
    else if (evt_vld && evt_rdy)
      map_vld <= 1'b1;
    else if (map_rdy)
      map_vld <= 1'b0;
  end

  // key register
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_vld && evt_rdy)
      map_key <= map_key_nxt;
  end

  // stalled output must not change
  map_key_hold: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
      map_vld && !map_rdy |=> map_vld && $stable(map_key))
    else $error("event_mapper: map_key changed under back-pressure");

endmodule

// File: hssl_cfg.svh
// --------------------------------------------------
// sizes and configuration address map of the router
// included ahead of the package and every RTL module
// --------------------------------------------------
`ifndef HSSL_CFG_SVH
`define HSSL_CFG_SVH

// --------------------------------------------------
// sizes
// --------------------------------------------------
`define HSSL_KEY_BITS       32
`define HSSL_NUM_CHANNELS   8
`define HSSL_ROUTE_BITS     3
`define HSSL_NUM_RREGS      8
`define HSSL_NUM_MREGS      4
`define HSSL_SHIFT_BITS     6
`define HSSL_CFG_ADDR_BITS  8

// --------------------------------------------------
// configuration address map, one word per entry
// --------------------------------------------------
`define HSSL_ADDR_MP_KEY    8'h00
`define HSSL_ADDR_MP_FMSK   8'h10
`define HSSL_ADDR_MP_FSFT   8'h14
`define HSSL_ADDR_RT_KEY    8'h20
`define HSSL_ADDR_RT_MASK   8'h30
`define HSSL_ADDR_RT_ROUTE  8'h40
`define HSSL_ADDR_DROP_WAIT 8'h50
`endif

// File: hssl_pkg.sv
// --------------------------------------------------
// shared types of the event-to-packet routing path
// --------------------------------------------------
`include "hssl_cfg.svh"

package hssl_pkg;

  // event word or multicast key
  typedef logic [`HSSL_KEY_BITS-1:0]      key_t;
  // output channel index
  typedef logic [`HSSL_ROUTE_BITS-1:0]    route_t;
  // mapper field shift
  typedef logic [`HSSL_SHIFT_BITS-1:0]    shift_t;
  typedef logic [`HSSL_CFG_ADDR_BITS-1:0] cfg_addr_t;

  // routing table columns
  typedef key_t   [`HSSL_NUM_RREGS-1:0] key_array_t;
  typedef route_t [`HSSL_NUM_RREGS-1:0] route_array_t;

  // event mapper fields
  typedef key_t   [`HSSL_NUM_MREGS-1:0] fmsk_array_t;
  typedef shift_t [`HSSL_NUM_MREGS-1:0] fsft_array_t;

endpackage

// File: route_table.sv
// --------------------------------------------------
// key/mask route lookup, lowest matching entry wins
// one registered valid/ready stage
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module route_table
  import hssl_pkg::*;
(
  input  logic         pl_clk0_buf_int,
  input  logic         rst_n,

  // mapped key from event_mapper
  input  key_t         map_key,
  input  logic         map_vld,
  output logic         map_rdy,

  // routing table contents
  input  key_array_t   rt_key,
  input  key_array_t   rt_mask,
  input  route_array_t rt_route,

  // routed key to router_ctrl
  output key_t         rtd_key,
  output route_t       rtd_route,
  output logic         rtd_hit,
  output logic         rtd_vld,
  input  logic         rtd_rdy
);

  logic   hit_nxt;
  route_t route_nxt;

  // ------------------------------------------------
  // lookup
  // ------------------------------------------------
  // scan from the top so the lowest match is the last one kept
  always_comb
  begin
    hit_nxt   = 1'b0;
    route_nxt = '0;
    for (int i = `HSSL_NUM_RREGS - 1; i >= 0; i--)
    begin
      if ((map_key & rt_mask[i]) == rt_key[i])
      begin
        hit_nxt   = 1'b1;
        route_nxt = rt_route[i];
      end
    end
  end

  // ------------------------------------------------
  // output stage
  // ------------------------------------------------
  assign map_rdy = !rtd_vld || rtd_rdy;

  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
      rtd_vld <= 1'b0;
    else if (map_vld && map_rdy)
      rtd_vld <= 1'b1;
    else if (rtd_rdy)
      rtd_vld <= 1'b0;
  end

  // key, route and hit travel together
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (map_vld && map_rdy)
    begin
      rtd_key   <= map_key;
      rtd_route <= route_nxt;
      rtd_hit   <= hit_nxt;
    end
  end

endmodule

// File: router_ctrl.sv
// --------------------------------------------------
// offers each routed packet on its channel
// drops it on a table miss or on drop timeout
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module router_ctrl
  import hssl_pkg::*;
(
  input  logic                          pl_clk0_buf_int,
  input  logic                          rst_n,

  // routed key from route_table
  input  key_t                          rtd_key,
  input  route_t                        rtd_route,
  input  logic                          rtd_hit,
  input  logic                          rtd_vld,
  output logic                          rtd_rdy,

  // channel outputs, key shared by all
  output key_t                          out_key,
  output logic [`HSSL_NUM_CHANNELS-1:0] out_vld,
  input  logic [`HSSL_NUM_CHANNELS-1:0] out_rdy,

  // drop timer
  output logic                          timer_start,
  output logic                          timer_stop,
  input  logic                          timer_expired,

  // statistics pulses
  output logic                          cnt_routed,
  output logic                          cnt_dropped
);

  typedef enum logic {IDLE, OFFER} state_t;

  state_t state;
  logic   take;
  logic   chan_rdy;

  // single packet holder
  assign rtd_rdy  = (state == IDLE);
  assign take     = rtd_vld && rtd_rdy;
  // ready of the one channel being offered
  assign chan_rdy = |(out_vld & out_rdy);

  // --------------------------------------------------
  // timer and counter pulses
  // --------------------------------------------------
  assign timer_start = take && rtd_hit;
  assign cnt_routed  = (state == OFFER) && chan_rdy;
  assign timer_stop  = cnt_routed;
  // miss drops at once, timeout loses to a late ready
  assign cnt_dropped = (take && !rtd_hit) ||
                       ((state == OFFER) && !chan_rdy && timer_expired);

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      out_vld <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (take && rtd_hit)
          begin
            state            <= OFFER;
            out_vld          <= '0;
            out_vld[rtd_route] <= 1'b1;
          end
        end
        default:
        begin
          if (chan_rdy || timer_expired)
          begin
            state   <= IDLE;
            out_vld <= '0;
          end
        end
      endcase
    end
  end

  // held key
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (take)
      out_key <= rtd_key;
  end

  out_onehot: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
      $onehot0(out_vld))
    else $error("router_ctrl: more than one out_vld bit high");

  // timer only fires while a packet is on offer
  expire_in_offer: assert property (@(posedge pl_clk0_buf_int) disable iff (!rst_n)
      timer_expired |-> state == OFFER)
    else $error("router_ctrl: timer expired with no packet offered");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
  --top-module tb_dvs_hssl_router -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb_checker.sv
// --------------------------------------------------
// checker that mirrors config and predicts packets
// compares every channel transfer and the counters
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module tb_checker
  import hssl_pkg::*;
(
  input  logic                          pl_clk0_buf_int,
  input  logic                          rst_n,
  input  cfg_addr_t                     cfg_addr,
  input  key_t                          cfg_wdata,
  input  logic                          cfg_en,
  input  key_t                          evt_data,
  input  logic                          evt_vld,
  input  logic                          evt_rdy,
  input  key_t                          out_key,
  input  logic [`HSSL_NUM_CHANNELS-1:0] out_vld,
  input  logic [`HSSL_NUM_CHANNELS-1:0] out_rdy,
  input  key_t                          routed_count,
  input  key_t                          dropped_count,
  input  logic                          end_check,
  output logic                          end_done,
  output int                            pending,
  output int                            value_errs,
  output int                            other_errs
);

  // mirrored configuration
  key_t   m_key;
  key_t   m_fmsk  [`HSSL_NUM_MREGS];
  shift_t m_fsft  [`HSSL_NUM_MREGS];
  key_t   r_key   [`HSSL_NUM_RREGS];
  key_t   r_mask  [`HSSL_NUM_RREGS];
  route_t r_route [`HSSL_NUM_RREGS];
  key_t   m_wait;

  // expected packets in arrival order
  key_t   exp_key_q [$];
  route_t exp_route_q [$];
  key_t   exp_routed;
  key_t   exp_dropped;
  key_t   wait_cnt;
  logic   expect_low;

  // reference model builds the key from the fields and takes the first matching entry
  function automatic logic expect_packet(input key_t evt, output key_t key, output route_t route);
    logic hit;
    key = m_key;
    for (int f = 0; f < `HSSL_NUM_MREGS; f++)
      key |= (evt & m_fmsk[f]) >> m_fsft[f];
    hit   = 1'b0;
    route = '0;
    for (int e = 0; e < `HSSL_NUM_RREGS; e++)
    begin
      if (!hit && ((key & r_mask[e]) == r_key[e]))
      begin
        hit   = 1'b1;
        route = r_route[e];
      end
    end
    return hit;
  endfunction

  // address decode by region nibble
  task mirror_write(input cfg_addr_t a, input key_t d);
    case (a[7:4])
      4'h0: if (a[3:0] == 4'h0)
              m_key = d;
      4'h1: if (a[3:2] == 2'b00)
              m_fmsk[a[1:0]] = d;
            else if (a[3:2] == 2'b01)
              m_fsft[a[1:0]] = d[`HSSL_SHIFT_BITS-1:0];
      4'h2: if (!a[3])
              r_key[a[2:0]] = d;
      4'h3: if (!a[3])
              r_mask[a[2:0]] = d;
      4'h4: if (!a[3])
              r_route[a[2:0]] = d[`HSSL_ROUTE_BITS-1:0];
      4'h5: if (a[3:0] == 4'h0)
              m_wait = d;
      default: ;
    endcase
  endtask

  task report_value(input string name, input key_t exp, input key_t act);
    value_errs++;
    $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
  endtask

  // --------------------------------------------------
  // compare on every rising edge
  // --------------------------------------------------
  always @(posedge pl_clk0_buf_int)
  begin : watch
    key_t                          k;
    route_t                        r;
    logic                          h;
    logic [`HSSL_NUM_CHANNELS-1:0] exp_vld;
    if (!rst_n)
    begin
      m_key       = '0;
      m_fmsk      = '{default: '0};
      m_fsft      = '{default: '0};
      r_key       = '{default: '0};
      r_mask      = '{default: '0};
      r_route     = '{default: '0};
      m_wait      = '0;
      exp_key_q.delete();
      exp_route_q.delete();
      exp_routed  = '0;
      exp_dropped = '0;
      wait_cnt    = '0;
      expect_low  = 1'b0;
      end_done    = 1'b0;
      value_errs  = 0;
      other_errs  = 0;
    end
    else
    begin
      // the cycle after a timeout drop must be quiet
      if (expect_low && out_vld != '0)
      begin
        other_errs++;
        $display("t=%0t: out_vld still high after the drop timeout", $time);
      end
      expect_low = 1'b0;
      if ($countones(out_vld) > 1)
      begin
        other_errs++;
        $display("t=%0t: more than one out_vld bit high", $time);
      end

      if (out_vld != '0)
      begin
        if (exp_key_q.size() == 0)
        begin
          other_errs++;
          $display("t=%0t: packet offered on out_vld with none expected", $time);
        end
        else if ((out_vld & out_rdy) != '0)
        begin
          exp_vld = '0;
          exp_vld[exp_route_q[0]] = 1'b1;
          if (out_vld != exp_vld)
            report_value("out_vld", key_t'(exp_vld), key_t'(out_vld));
          if (out_key != exp_key_q[0])
            report_value("out_key", exp_key_q[0], out_key);
          void'(exp_key_q.pop_front());
          void'(exp_route_q.pop_front());
          wait_cnt = '0;
        end
        else
        begin
          // a stalled offer counts toward the drop wait
          wait_cnt += key_t'(1);
          if (m_wait != '0 && wait_cnt == m_wait)
          begin
            void'(exp_key_q.pop_front());
            void'(exp_route_q.pop_front());
            exp_routed  -= key_t'(1);
            exp_dropped += key_t'(1);
            wait_cnt     = '0;
            expect_low   = 1'b1;
          end
        end
      end

      // accepted event is predicted with the config in force
      // and a hit counts as routed until a timeout drops it
      if (evt_vld && evt_rdy)
      begin
        h = expect_packet(evt_data, k, r);
        if (h)
        begin
          exp_key_q.push_back(k);
          exp_route_q.push_back(r);
          exp_routed += key_t'(1);
        end
        else
          exp_dropped += key_t'(1);
      end

      if (cfg_en)
        mirror_write(cfg_addr, cfg_wdata);

      if (end_check && !end_done)
      begin
        if (routed_count != exp_routed)
          report_value("routed_count", exp_routed, routed_count);
        if (dropped_count != exp_dropped)
          report_value("dropped_count", exp_dropped, dropped_count);
        if (exp_key_q.size() != 0)
        begin
          other_errs++;
          $display("t=%0t: %0d expected packets were never delivered", $time, exp_key_q.size());
        end
        end_done = 1'b1;
      end
    end
    pending = exp_key_q.size();
  end

endmodule

// File: tb_dvs_hssl_router.sv
// --------------------------------------------------
// testbench top for the event-to-packet router
// drives config, events and channel ready, ends run
// --------------------------------------------------
`include "hssl_cfg.svh"

`timescale 1ns/10ps
module tb_dvs_hssl_router
  import hssl_pkg::*;
();

  localparam int CLK_PERIOD  = 8;
  localparam int DROP_N      = 5;
  localparam int N_RANDOM    = 24;
  localparam int N_STREAM    = 200;
  localparam int NUM_EVENTS  = 8 + N_RANDOM + 2 + N_STREAM;
  localparam int CFG_CYCLES  = 64;
  // worst case per event is a full drop wait plus slack
  localparam int WATCHDOG_NS = (NUM_EVENTS * (DROP_N + 10) + CFG_CYCLES) * CLK_PERIOD;

  logic                          pl_clk0_buf_int;
  logic                          rst_n;
  cfg_addr_t                     cfg_addr;
  key_t                          cfg_wdata;
  logic                          cfg_en;
  key_t                          evt_data;
  logic                          evt_vld;
  logic                          evt_rdy;
  key_t                          out_key;
  logic [`HSSL_NUM_CHANNELS-1:0] out_vld;
  logic [`HSSL_NUM_CHANNELS-1:0] out_rdy;
  key_t                          routed_count;
  key_t                          dropped_count;

  // checker handshake and results
  logic                          end_check;
  logic                          end_done;
  int                            pending;
  int                            value_errs;
  int                            other_errs;

  integer                        seed;
  integer                        rnd;
  logic                          rdy_random;

  // priority, multi-match, single-entry and miss cases
  key_t directed [8] = '{32'h3, 32'h53, 32'h50, 32'h4, 32'h0, 32'h1, 32'h100, 32'h0F00_0000};

  always #(CLK_PERIOD / 2) pl_clk0_buf_int = ~pl_clk0_buf_int;

  dvs_hssl_router_top UUT (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .cfg_addr        (cfg_addr)
    , .cfg_wdata       (cfg_wdata)
    , .cfg_en          (cfg_en)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .out_key         (out_key)
    , .out_vld         (out_vld)
    , .out_rdy         (out_rdy)
    , .routed_count    (routed_count)
    , .dropped_count   (dropped_count)
    );

  tb_checker chk (
      .pl_clk0_buf_int (pl_clk0_buf_int)
    , .rst_n           (rst_n)
    , .cfg_addr        (cfg_addr)
    , .cfg_wdata       (cfg_wdata)
    , .cfg_en          (cfg_en)
    , .evt_data        (evt_data)
    , .evt_vld         (evt_vld)
    , .evt_rdy         (evt_rdy)
    , .out_key         (out_key)
    , .out_vld         (out_vld)
    , .out_rdy         (out_rdy)
    , .routed_count    (routed_count)
    , .dropped_count   (dropped_count)
    , .end_check       (end_check)
    , .end_done        (end_done)
    , .pending         (pending)
    , .value_errs      (value_errs)
    , .other_errs      (other_errs)
    );

  // --------------------------------------------------
  // stimulus helpers, all on the falling edge
  // --------------------------------------------------
  task next_cycle();
    @(negedge pl_clk0_buf_int);
    // random channel back-pressure
    if (rdy_random)
    begin
      rnd     = $random(seed);
      out_rdy = rnd[`HSSL_NUM_CHANNELS-1:0];
    end
  endtask

  task cfg_write(input cfg_addr_t addr, input key_t data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_en    = 1'b1;
    next_cycle();
    cfg_en    = 1'b0;
  endtask

  task route_entry(input int idx, input key_t mask, input key_t key, input int route);
    cfg_write(`HSSL_ADDR_RT_KEY + 8'(idx), key);
    cfg_write(`HSSL_ADDR_RT_MASK + 8'(idx), mask);
    cfg_write(`HSSL_ADDR_RT_ROUTE + 8'(idx), key_t'(route));
  endtask

  task configure();
    cfg_write(`HSSL_ADDR_MP_KEY, 32'h8000_0000);
    // four nibble fields packed into the low 16 key bits
    for (int i = 0; i < `HSSL_NUM_MREGS; i++)
    begin
      cfg_write(`HSSL_ADDR_MP_FMSK + 8'(i), 32'hF << (8 * i));
      cfg_write(`HSSL_ADDR_MP_FSFT + 8'(i), key_t'(4 * i));
    end
    // entries 0..3 overlap on the low byte
    route_entry(0, 32'hF, 32'h3, 5);
    route_entry(1, 32'h3, 32'h3, 2);
    route_entry(2, 32'hF0, 32'h50, 7);
    route_entry(3, 32'h7, 32'h4, 1);
    // bit 31 is always set by mp_key, never matches
    route_entry(4, 32'h8000_0000, 32'h0, 6);
    for (int i = 5; i < `HSSL_NUM_RREGS; i++)
      route_entry(i, 32'h0, 32'h1, i);
    // unmapped address, must be ignored
    cfg_write(8'h66, 32'hFFFF_FFFF);
  endtask

  task send_event(input key_t data);
    evt_data = data;
    evt_vld  = 1'b1;
    // evt_rdy only moves on the rising edge
    while (!evt_rdy)
      next_cycle();
    next_cycle();
    evt_vld  = 1'b0;
  endtask

  task drain();
    while (pending != 0)
      next_cycle();
    // three single-cycle stages flush any trailing misses
    repeat (4)
      next_cycle();
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    seed            = 4173;
    pl_clk0_buf_int = 1'b0;
    rst_n           = 1'b0;
    cfg_addr        = '0;
    cfg_wdata       = '0;
    cfg_en          = 1'b0;
    evt_data        = '0;
    evt_vld         = 1'b0;
    out_rdy         = '1;
    end_check       = 1'b0;
    rdy_random      = 1'b0;
    repeat (3)
      @(negedge pl_clk0_buf_int);
    rst_n = 1'b1;
    configure();

    // mapping, priority and misses, channels always ready
    foreach (directed[i])
      send_event(directed[i]);
    for (int i = 0; i < N_RANDOM; i++)
    begin
      rnd = $random(seed);
      send_event(rnd);
    end
    drain();

    // timeout, two hits offered to channels held low
    cfg_write(`HSSL_ADDR_DROP_WAIT, key_t'(DROP_N));
    out_rdy = '0;
    send_event(32'h3);
    send_event(32'h7);
    drain();
    out_rdy = '1;
    cfg_write(`HSSL_ADDR_DROP_WAIT, 32'd0);

    // stream under random back-pressure, wait forever
    rdy_random = 1'b1;
    for (int i = 0; i < N_STREAM; i++)
    begin
      rnd = $random(seed);
      send_event(rnd);
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00)
        next_cycle();
    end
    rdy_random = 1'b0;
    out_rdy    = '1;
    drain();

    // final counter compare in the checker
    end_check = 1'b1;
    while (!end_done)
      next_cycle();
    end_check = 1'b0;

    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog timeout after %0d ns, %0d expected packets never left the router",
             WATCHDOG_NS, pending);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
